// ==== hdl/gb_mem_map_pkg.sv ====
// Memory map of the CPU bus
`default_nettype none

package gb_mem_map_pkg;

    // Work RAM window, 8 KB
    localparam logic [15:0] wram_base = 16'hC000;
    // Byte port address width
    localparam int wram_addr_width = 13;
    // Wide port addresses 16-bit words
    localparam int wram_word_width = 12;

    // Object attribute memory window
    localparam logic [15:0] oam_base = 16'hFE00;
    // Only 160 of the 256 bytes are mapped
    localparam int oam_bytes = 160;
    localparam int oam_addr_width = 8;
    localparam int oam_word_width = 7;

    // High RAM, FF80 to FFFE
    localparam logic [15:0] hram_base = 16'hFF80;
    // FFFF is not part of High RAM
    localparam logic [15:0] hram_last = 16'hFFFE;
    localparam int hram_addr_width = 7;

    // Value seen on an undriven or locked bus
    localparam logic [7:0] open_bus = 8'hFF;

endpackage

`default_nettype wire

// ==== hdl/gb_dma_pkg.sv ====
// OAM DMA definitions
`default_nettype none

package gb_dma_pkg;

    // Write here to start a copy
    localparam logic [15:0] dma_reg_addr = 16'hFF46;

    // 160 bytes moved as 16-bit words
    localparam int dma_words = 80;

    // Engine state
    typedef enum logic {
        idle,
        copy
    } dma_state_t;

endpackage

`default_nettype wire

// ==== hdl/ram_port_if.sv ====
// RAM port bundle
`default_nettype none

interface ram_port_if #(
    parameter int addr_width = 8,
    parameter int data_width = 8
);

    // Word address
    logic [addr_width-1:0] address;
    // Write data
    logic [data_width-1:0] data;
    // Write enable, taken at the clock edge
    logic                  wren;
    // Combinational read data
    logic [data_width-1:0] q;

    // Side that issues accesses
    modport host (
        output address,
        output data,
        output wren,
        input  q
    );

    // Side that holds the storage
    modport ram (
        input  address,
        input  data,
        input  wren,
        output q
    );

endinterface

`default_nettype wire

// ==== hdl/dpram.sv ====
// True dual-port RAM
`default_nettype none

module dpram #(
    parameter int addr_width = 7,
    parameter int data_width = 8
) (
    input logic      clka,
    ram_port_if.ram  port_a,
    ram_port_if.ram  port_b
);

    localparam int depth = 2 ** addr_width;

    logic [data_width-1:0] mem [depth];

    // Start from a known state in simulation
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = '0;
        end
    end

    // Both writes on the one clock
    // Port B is applied last so it wins on a shared address
    always @(posedge clka) begin
        if (port_a.wren) begin
            mem[port_a.address] <= port_a.data;
        end
        if (port_b.wren) begin
            mem[port_b.address] <= port_b.data;
        end
    end

    // Zero-latency reads
    assign port_a.q = mem[port_a.address];
    assign port_b.q = mem[port_b.address];

endmodule

`default_nettype wire

// ==== hdl/dpram_dif.sv ====
// Mixed-width dual-port RAM
`default_nettype none

module dpram_dif #(
    parameter int addr_width_a = 13,
    parameter int addr_width_b = 12
) (
    input logic      clka,
    ram_port_if.ram  port_a,
    ram_port_if.ram  port_b
);

    // Byte count of each port's address space
    localparam int bytes_a = 2 ** addr_width_a;
    localparam int bytes_b = 2 ** (addr_width_b + 1);
    // Storage covers the larger of the two
    localparam int mem_size = (bytes_a > bytes_b) ? bytes_a : bytes_b;

    // Byte-granular storage
    logic [7:0] mem [mem_size];

    // Byte addresses of the port B pair
    logic [addr_width_b:0] lo_addr;
    logic [addr_width_b:0] hi_addr;

    assign lo_addr = {port_b.address, 1'b0};
    assign hi_addr = {port_b.address, 1'b1};

    initial begin
        for (int i = 0; i < mem_size; i++) begin
            mem[i] = 8'h00;
        end
    end

    // Byte write first, word write second
    // so the wide port overrides on overlap
    always @(posedge clka) begin
        if (port_a.wren) begin
            mem[port_a.address] <= port_a.data;
        end
        if (port_b.wren) begin
            // Little-endian pair
            mem[lo_addr] <= port_b.data[7:0];
            mem[hi_addr] <= port_b.data[15:8];
        end
    end

    // Byte read
    assign port_a.q = mem[port_a.address];
    // Word read, high byte at the odd address
    assign port_b.q = {mem[hi_addr], mem[lo_addr]};

endmodule

`default_nettype wire

// ==== hdl/oam_dma.sv ====
// OAM DMA engine
`default_nettype none

module oam_dma (
    input  logic        clka,
    input  logic        arst_n,
    input  logic        dma_start,
    input  logic [4:0]  dma_page,
    input  logic [6:0]  ppu_oam_addr,
    output logic [15:0] ppu_oam_data,
    output logic        dma_busy,
    ram_port_if.host    wram_b,
    ram_port_if.host    oam_b
);

    import gb_dma_pkg::*;

    // Last word index of a transfer
    localparam logic [6:0] last_word = 7'(dma_words - 1);

    dma_state_t state;
    // Word being copied this cycle
    logic [6:0] word_cnt;
    // Source page, held for the whole copy
    logic [4:0] src_page;

    always_ff @(posedge clka or negedge arst_n) begin
        if (!arst_n) begin
            state    <= idle;
            word_cnt <= '0;
            src_page <= '0;
        end else begin
            case (state)
                idle: begin
                    if (dma_start) begin
                        state    <= copy;
                        word_cnt <= '0;
                        src_page <= dma_page;
                    end
                end
                copy: begin
                    // Word 79 is written at this edge
                    if (word_cnt == last_word) begin
                        state    <= idle;
                        word_cnt <= '0;
                    end else begin
                        word_cnt <= word_cnt + 7'd1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    assign dma_busy = (state == copy);

    // Source word is page * 128 + counter, read-only side
    assign wram_b.address = {src_page, word_cnt};
    assign wram_b.data    = '0;
    assign wram_b.wren    = 1'b0;

    // OAM wide port belongs to the copy while busy
    // and to the video reader otherwise
    assign oam_b.address = dma_busy ? word_cnt : ppu_oam_addr;
    assign oam_b.data    = wram_b.q;
    assign oam_b.wren    = dma_busy;

    // Video sees whatever the wide port addresses
    assign ppu_oam_data = oam_b.q;

endmodule

`default_nettype wire

// ==== hdl/mem_ctrl.sv ====
// CPU bus decoder and DMA register
`default_nettype none

module mem_ctrl (
    input  logic        clka,
    input  logic        arst_n,
    input  logic [15:0] cpu_addr,
    input  logic [7:0]  cpu_wdata,
    input  logic        cpu_wr,
    output logic [7:0]  cpu_rdata,
    input  logic        dma_busy,
    output logic        dma_start,
    output logic [4:0]  dma_page,
    ram_port_if.host    hram_a,
    ram_port_if.host    wram_a,
    ram_port_if.host    oam_a
);

    import gb_mem_map_pkg::*;
    import gb_dma_pkg::*;

    // Region selects
    logic in_wram;
    logic in_oam;
    logic in_hram;
    logic in_dma_reg;

    // Last value written to FF46
    logic [7:0] dma_reg;
    // Register write accepted this cycle
    logic       dma_reg_wr;

    // Work RAM is one aligned 8 KB block
    assign in_wram = (cpu_addr[15:wram_addr_width] == wram_base[15:wram_addr_width]);

    // OAM stops short of its 256-byte page
    assign in_oam = (cpu_addr >= oam_base) && (cpu_addr < oam_base + 16'(oam_bytes));

    assign in_hram = (cpu_addr >= hram_base) && (cpu_addr <= hram_last);

    assign in_dma_reg = (cpu_addr == dma_reg_addr);

    // Ignored while a copy runs or is about to start
    assign dma_reg_wr = cpu_wr && in_dma_reg && !dma_busy && !dma_start;

    always_ff @(posedge clka or negedge arst_n) begin
        if (!arst_n) begin
            dma_reg   <= 8'h00;
            dma_start <= 1'b0;
        end else begin
            // Start pulse lasts one cycle
            dma_start <= dma_reg_wr;
            if (dma_reg_wr) begin
                dma_reg <= cpu_wdata;
            end
        end
    end

    // Source page taken modulo the work RAM
    assign dma_page = dma_reg[4:0];

    // High RAM stays reachable during a copy
    assign hram_a.address = cpu_addr[hram_addr_width-1:0];
    assign hram_a.data    = cpu_wdata;
    assign hram_a.wren    = cpu_wr && in_hram;

    // Work RAM locked out during a copy
    assign wram_a.address = cpu_addr[wram_addr_width-1:0];
    assign wram_a.data    = cpu_wdata;
    assign wram_a.wren    = cpu_wr && in_wram && !dma_busy;

    // OAM locked out as well
    assign oam_a.address = cpu_addr[oam_addr_width-1:0];
    assign oam_a.data    = cpu_wdata;
    assign oam_a.wren    = cpu_wr && in_oam && !dma_busy;

    // Read-data mux
    always_comb begin
        if (in_hram) begin
            cpu_rdata = hram_a.q;
        end else if (dma_busy) begin
            // Everything else floats while busy
            cpu_rdata = open_bus;
        end else if (in_wram) begin
            cpu_rdata = wram_a.q;
        end else if (in_oam) begin
            cpu_rdata = oam_a.q;
        end else if (in_dma_reg) begin
            cpu_rdata = dma_reg;
        end else begin
            // Unmapped
            cpu_rdata = open_bus;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/gb_mem_top.sv ====
// Memory block top level
`default_nettype none

module gb_mem_top (
    input  logic        clka,
    input  logic        arst_n,
    input  logic [15:0] cpu_addr,
    input  logic [7:0]  cpu_wdata,
    input  logic        cpu_wr,
    output logic [7:0]  cpu_rdata,
    input  logic [6:0]  ppu_oam_addr,
    output logic [15:0] ppu_oam_data,
    output logic        dma_busy
);

    import gb_mem_map_pkg::*;

    // Controller to DMA
    logic       dma_start;
    logic [4:0] dma_page;

    // CPU side ports
    ram_port_if #(.addr_width(hram_addr_width), .data_width(8)) hram_a ();
    ram_port_if #(.addr_width(wram_addr_width), .data_width(8)) wram_a ();
    ram_port_if #(.addr_width(oam_addr_width),  .data_width(8)) oam_a ();

    // DMA side wide ports
    ram_port_if #(.addr_width(wram_word_width), .data_width(16)) wram_b ();
    ram_port_if #(.addr_width(oam_word_width),  .data_width(16)) oam_b ();

    // Spare High RAM port
    ram_port_if #(.addr_width(hram_addr_width), .data_width(8)) hram_b ();

    // Never accessed
    assign hram_b.address = '0;
    assign hram_b.data    = '0;
    assign hram_b.wren    = 1'b0;

    mem_ctrl u_mem_ctrl (
        .clka      (clka),
        .arst_n    (arst_n),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_wr    (cpu_wr),
        .cpu_rdata (cpu_rdata),
        .dma_busy  (dma_busy),
        .dma_start (dma_start),
        .dma_page  (dma_page),
        .hram_a    (hram_a),
        .wram_a    (wram_a),
        .oam_a     (oam_a)
    );

    oam_dma u_oam_dma (
        .clka         (clka),
        .arst_n       (arst_n),
        .dma_start    (dma_start),
        .dma_page     (dma_page),
        .ppu_oam_addr (ppu_oam_addr),
        .ppu_oam_data (ppu_oam_data),
        .dma_busy     (dma_busy),
        .wram_b       (wram_b),
        .oam_b        (oam_b)
    );

    dpram #(
        .addr_width (hram_addr_width),
        .data_width (8)
    ) u_hram (
        .clka   (clka),
        .port_a (hram_a),
        .port_b (hram_b)
    );

    dpram_dif #(
        .addr_width_a (wram_addr_width),
        .addr_width_b (wram_word_width)
    ) u_wram (
        .clka   (clka),
        .port_a (wram_a),
        .port_b (wram_b)
    );

    dpram_dif #(
        .addr_width_a (oam_addr_width),
        .addr_width_b (oam_word_width)
    ) u_oam (
        .clka   (clka),
        .port_a (oam_a),
        .port_b (oam_b)
    );

endmodule

`default_nettype wire

// ==== dv/gb_mem_tb.sv ====
// Memory block testbench
`default_nettype none

module gb_mem_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import gb_mem_map_pkg::*;
    import gb_dma_pkg::*;

    // Longest wait in cycles for a copy to end
    localparam int busy_timeout = 200;

    logic        clka;
    logic        arst_n;
    logic [15:0] cpu_addr;
    logic [7:0]  cpu_wdata;
    logic        cpu_wr;
    logic [7:0]  cpu_rdata;
    logic [6:0]  ppu_oam_addr;
    logic [15:0] ppu_oam_data;
    logic        dma_busy;

    int seed = 5;
    int errors = 0;
    int checks = 0;
    bit abort = 0;
    // Rising edges since time zero
    int edge_cnt = 0;
    // Edge of the last accepted FF46 write
    int start_edge = 0;
    // Set by an accepted FF46 write until its copy has been waited out
    bit copy_pending = 0;
    logic [7:0] last_page = 8'h00;
    // Expected work RAM bytes with index 0 at C000
    logic [7:0] wram_model [2 ** wram_addr_width];

    gb_mem_top u_gb_mem_top (
        .clka         (clka),
        .arst_n       (arst_n),
        .cpu_addr     (cpu_addr),
        .cpu_wdata    (cpu_wdata),
        .cpu_wr       (cpu_wr),
        .cpu_rdata    (cpu_rdata),
        .ppu_oam_addr (ppu_oam_addr),
        .ppu_oam_data (ppu_oam_data),
        .dma_busy     (dma_busy)
    );

    // 20 ns clock
    initial begin
        clka = 1'b0;
        forever #10 clka = ~clka;
    end

    always @(posedge clka) begin
        edge_cnt <= edge_cnt + 1;
    end

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] expected);
        checks++;
        if (got !== expected) begin
            $display("FAIL at %0t: %s got %h, expected %h", $time, name, got, expected);
            errors++;
        end
    endtask

    // Drive after a falling edge and hold to the next one
    task automatic run_cycle(input logic [15:0] addr, input logic [7:0] wdata, input logic wr);
        cpu_addr  = addr;
        cpu_wdata = wdata;
        cpu_wr    = wr;
        @(negedge clka);
        cpu_wr    = 1'b0;
    endtask

    // Waits for the started copy to end and checks its length
    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (dma_busy && cycles < busy_timeout) begin
            @(negedge clka);
            cycles++;
        end
        copy_pending = 0;
        if (dma_busy) begin
            $display("Timeout: dma_busy still high after %0d cycles", busy_timeout);
            errors++;
            abort = 1;
        end else begin
            // Busy from the edge after the start edge up to the fall edge
            check_value("busy_length", 16'(edge_cnt - start_edge - 1), 16'(dma_words));
        end
    endtask

    task automatic run_op(input logic [7:0] op, input logic [31:0] arg_a,
                          input logic [31:0] arg_b);
        logic [7:0]  data_byte;
        logic [12:0] lo_idx;
        logic [12:0] hi_idx;
        bit          was_busy;
        case (op)
            "W": run_cycle(16'(arg_a), 8'(arg_b), 1'b1);
            "R": begin
                run_cycle(16'(arg_a), 8'h00, 1'b0);
                check_value("cpu_rdata", 16'(cpu_rdata), 16'(arg_b));
            end
            "D": begin
                was_busy = dma_busy;
                run_cycle(dma_reg_addr, 8'(arg_a), 1'b1);
                // A write during a copy changes nothing
                if (!was_busy) begin
                    start_edge   = edge_cnt;
                    last_page    = 8'(arg_a);
                    copy_pending = 1;
                end
            end
            "B": begin
                @(negedge clka);
                if (arg_a == 0 && copy_pending) begin
                    // A started copy runs to its end first
                    wait_idle();
                end else begin
                    check_value("dma_busy", 16'(dma_busy), 16'(arg_a));
                end
            end
            "P": begin
                ppu_oam_addr = 7'(arg_a);
                @(negedge clka);
                check_value("ppu_oam_data", ppu_oam_data, 16'(arg_b));
            end
            "F": begin
                // Random bytes from C000 up that are kept in the model
                for (int i = 0; i < int'(arg_a); i++) begin
                    data_byte = 8'($random(seed));
                    wram_model[13'(i)] = data_byte;
                    run_cycle(wram_base + 16'(i), data_byte, 1'b1);
                end
            end
            "O": begin
                // Source bytes of OAM word n with the page taken modulo the work RAM
                lo_idx = {last_page[4:0], 7'(arg_a), 1'b0};
                hi_idx = {last_page[4:0], 7'(arg_a), 1'b1};
                ppu_oam_addr = 7'(arg_a);
                run_cycle(oam_base + 16'(lo_idx[7:0]), 8'h00, 1'b0);
                check_value("ppu_oam_data", ppu_oam_data,
                            {wram_model[hi_idx], wram_model[lo_idx]});
                check_value("cpu_rdata", 16'(cpu_rdata), 16'(wram_model[lo_idx]));
                // Odd byte through the CPU side
                run_cycle(oam_base + 16'(hi_idx[7:0]), 8'h00, 1'b0);
                check_value("cpu_rdata", 16'(cpu_rdata), 16'(wram_model[hi_idx]));
            end
            default: begin
                $display("Unknown opcode %c in the stim file", op);
                errors++;
                abort = 1;
            end
        endcase
    endtask

    initial begin
        int               fd;
        int               n;
        int               nargs;
        bit               done;
        logic [7:0]       op;
        logic [31:0]      arg_a;
        logic [31:0]      arg_b;
        logic [8*128-1:0] line;
        cpu_addr     = 16'h0000;
        cpu_wdata    = 8'h00;
        cpu_wr       = 1'b0;
        ppu_oam_addr = 7'h00;
        arst_n       = 1'b0;
        done         = 0;
        arg_a        = 0;
        arg_b        = 0;
        repeat (10) @(negedge clka);
        arst_n = 1'b1;
        fd = $fopen("dv/gb_mem_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open dv/gb_mem_stim.txt");
            errors++;
            abort = 1;
        end
        while (!abort && !done) begin
            n = $fscanf(fd, " %c", op);
            if (n != 1) begin
                done = 1;
            end else if (op == "#") begin
                // Skip the rest of a comment line
                n = $fgets(line, fd);
            end else begin
                nargs = (op == "W" || op == "R" || op == "P") ? 2 : 1;
                if (nargs == 2) begin
                    n = $fscanf(fd, "%h %h", arg_a, arg_b);
                end else begin
                    n = $fscanf(fd, "%h", arg_a);
                end
                if (n != nargs) begin
                    $display("Stim line for opcode %c is missing a value", op);
                    errors++;
                    abort = 1;
                end else begin
                    run_op(op, arg_a, arg_b);
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== gb_mem.f ====
hdl/gb_mem_map_pkg.sv
hdl/gb_dma_pkg.sv
hdl/ram_port_if.sv
hdl/dpram.sv
hdl/dpram_dif.sv
hdl/oam_dma.sv
hdl/mem_ctrl.sv
hdl/gb_mem_top.sv
dv/gb_mem_tb.sv

// ==== Makefile ====
# Verilator flow for the memory block

VERILATOR ?= verilator
TOP       ?= gb_mem_tb
FILELIST  ?= gb_mem.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Passes only when the pass line shows up in the run output
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/gb_mem_stim.txt ====
# opcode then hex fields: W addr data, R addr expected, D page, B expected,
# P word expected, F count, O word; B 0 also waits out a running DMA
B 0
R FF46 00
W C010 5A
R C010 5A
W FFFE 3C
R FFFE 3C
W FE00 12
W FE01 34
P 0 3412
R FE01 34
R A000 FF
R FF00 FF
F 200
D C1
B 1
W C105 AA
R C105 FF
W FE10 55
R FE10 FF
W FF90 C3
R FF90 C3
D 00
B 0
R FF46 C1
O 2
O 4F
W FE9F 00
D E1
B 0
O 4F
R FF46 E1
O 0
